/* aluPipe.f */
+incdir+sim
hdl/aluPkg.sv
hdl/busPkg.sv
hdl/aluShifter.sv
hdl/bcdAdjust.sv
hdl/ccrUnit.sv
hdl/aluExecute.sv
hdl/cmdDecode.sv
hdl/aluPipe.sv
sim/aluPipeTb.sv

/* Makefile */
SIM = obj_dir/ValuPipeTb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): aluPipe.f hdl/*.sv sim/aluPipeTb.sv sim/aluModel.svh
	verilator --binary --timing --assert --top-module aluPipeTb -f aluPipe.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

/* sim/aluModel.svh */
////////////////////
// Expected result and CCR per 68000 rules; returns {ccr, result}, byte results zero-extended
////////////////////
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

function automatic logic [20:0] modelExec(aluPkg::aluOp op, logic isByte, logic [15:0] a,
		logic [15:0] b, logic [4:0] ccrOld);
	logic byteOp, c, v, x, z, msb, sIn;
	logic [15:0] m, aa, r;
	int w, ua, ub, ur, sa, sb, sr, dR;
	byteOp = (op == aluPkg::opAbcd || op == aluPkg::opSbcd) ? 1'b1 : isByte;
	if (op == aluPkg::opExt)
		byteOp = 1'b0;                          // EXT always gives a word
	w = byteOp ? 8 : 16;
	m = byteOp ? 16'h00ff : 16'hffff;
	aa = a & m;
	msb = aa[w-1];
	c = 1'b0;
	v = 1'b0;
	x = ccrOld[4];
	sIn = 1'b0;
	case (op)
		aluPkg::opAnd: r = a & b;
		aluPkg::opOr:  r = a | b;
		aluPkg::opEor: r = a ^ b;
		aluPkg::opNot: r = ~a;
		aluPkg::opExt: r = {{8{a[7]}}, a[7:0]};
		aluPkg::opAdd, aluPkg::opAddx, aluPkg::opSub, aluPkg::opSubx, aluPkg::opCmp: begin
			sIn = (op == aluPkg::opAddx || op == aluPkg::opSubx) ? ccrOld[4] : 1'b0;
			ua = int'(aa);
			ub = int'(b & m);
			sa = byteOp ? int'($signed(a[7:0])) : int'($signed(a));
			sb = byteOp ? int'($signed(b[7:0])) : int'($signed(b));
			if (op == aluPkg::opAdd || op == aluPkg::opAddx) begin
				ur = ub + ua + int'(sIn);
				sr = sb + sa + int'(sIn);
				c = ur > int'(m);
			end else begin
				ur = ub - ua - int'(sIn);
				sr = sb - sa - int'(sIn);
				c = ur < 0;                     // Borrow
			end
			r = 16'(ur);
			v = (sr > (byteOp ? 127 : 32767)) || (sr < (byteOp ? -128 : -32768));
			if (op != aluPkg::opCmp)
				x = c;
		end
		aluPkg::opAbcd, aluPkg::opSbcd: begin
			ua = int'(a[7:4]) * 10 + int'(a[3:0]);
			ub = int'(b[7:4]) * 10 + int'(b[3:0]);
			dR = (op == aluPkg::opAbcd) ? ub + ua + int'(ccrOld[4]) : ub - ua - int'(ccrOld[4]);
			c = (dR > 99) || (dR < 0);
			dR = (dR + 100) % 100;
			r = {8'h00, 4'(dR / 10), 4'(dR % 10)};
			x = c;
		end
		default: begin                          // Shifts and rotates
			case (op)
				aluPkg::opAsr, aluPkg::opRol: sIn = msb;
				aluPkg::opRor: sIn = aa[0];
				aluPkg::opRoxl, aluPkg::opRoxr: sIn = ccrOld[4];
				default: sIn = 1'b0;
			endcase
			if (op == aluPkg::opAsl || op == aluPkg::opLsl || op == aluPkg::opRol ||
					op == aluPkg::opRoxl) begin
				c = msb;
				r = (aa << 1) | 16'(sIn);
			end else begin
				c = aa[0];
				r = (aa >> 1) | (16'(sIn) << (w - 1));
			end
			if (op == aluPkg::opAsl)
				v = msb ^ aa[w-2];              // Sign changed
			if (op != aluPkg::opRol && op != aluPkg::opRor)
				x = c;
		end
	endcase
	r = r & m;
	z = (r == 16'h0000);
	if (op == aluPkg::opAddx || op == aluPkg::opSubx || op == aluPkg::opAbcd ||
			op == aluPkg::opSbcd)
		z = z & ccrOld[2];                      // Sticky Z
	return {x, r[w-1], z, v, c, r};
endfunction

`endif

/* sim/aluPipeTb.sv */
////////////////////
// Testbench for aluPipe; BCD checks skip V, its value is undefined on the 68000
////////////////////
`timescale 1ns/1ns
`default_nettype none

module aluPipeTb;

	`include "aluModel.svh"

	logic clk = 1'b0;
	logic rstN = 1'b0;
	busPkg::wbReq req = '0;
	busPkg::wbRsp rsp;
	busPkg::aluRes res;
	int seed = 32'h2a79;
	int valueErrs = 0;
	int protoErrs = 0;
	logic [4:0] modelCcr = '0;                  // CCR in issue order
	logic [4:0] ccrKnown = 5'b11111;            // CCR bits the model predicts
	logic [20:0] expQ[$];
	logic [4:0] maskQ[$];
	logic wrAck1, wrAck2;
	aluPkg::aluOp allOps[20];

	aluPipe dut_i (.clk(clk), .rstN(rstN), .wbIn(req), .wbOut(rsp), .res(res));

	always #10 clk = ~clk;

	// Command acks delayed to the result cycle
	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrAck1 <= 1'b0;
			wrAck2 <= 1'b0;
		end else begin
			wrAck1 <= rsp.ack & req.we & req.cyc & req.stb & ~req.adr;
			wrAck2 <= wrAck1;
		end
	end

	ackPulse: assert property (@(posedge clk) disable iff (!rstN) rsp.ack |=> !rsp.ack)
		else begin
			protoErrs++;
			$display("ack stayed high two cycles at %0t", $time);
		end
	ackInReq: assert property (@(posedge clk) disable iff (!rstN)
			rsp.ack |-> (req.cyc && req.stb))
		else begin
			protoErrs++;
			$display("ack without cyc and stb at %0t", $time);
		end
	resTiming: assert property (@(posedge clk) disable iff (!rstN) res.valid == wrAck2)
		else begin
			protoErrs++;
			$display("res.valid not two cycles after a write ack at %0t", $time);
		end

	// Result monitor, sampled mid-cycle
	always @(negedge clk) begin
		logic [20:0] exp;
		logic [4:0] msk;
		if (rstN && res.valid) begin
			if (expQ.size() == 0) begin
				protoErrs++;
				$display("result appeared with no command pending at %0t", $time);
			end else begin
				exp = expQ.pop_front();
				msk = maskQ.pop_front();
				resCheck: assert (res.result == exp[15:0] &&
						(res.ccr & msk) == (exp[20:16] & msk))
					else begin
						valueErrs++;
						$display("mismatch at %0t: result %h ccr %b, expected %h ccr %b", $time,
							res.result, res.ccr, exp[15:0], exp[20:16]);
					end
			end
		end
	end

	task automatic finishRun();
		$display("errors: %0d value, %0d protocol, %0d results missing", valueErrs, protoErrs,
			expQ.size());
		if (valueErrs == 0 && protoErrs == 0 && expQ.size() == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	// Drive one request and return in its ack cycle
	task automatic busCycle(logic we, logic adr, busPkg::aluCmd cmd);
		busPkg::wbReq r;
		int n;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we = we;
		r.adr = adr;
		r.dat = cmd;
		n = 0;
		@(posedge clk);
		req <= r;
		@(negedge clk);
		while (!rsp.ack) begin
			if (n > 20) begin
				protoErrs++;
				$display("timed out waiting for ack");
				finishRun();
			end
			n++;
			@(negedge clk);
		end
	endtask

	task automatic busIdle();
		@(posedge clk);
		req.cyc <= 1'b0;
		req.stb <= 1'b0;
	endtask

	task automatic runCmd(aluPkg::aluOp op, logic isByte, logic [15:0] a, logic [15:0] b);
		busPkg::aluCmd cmd;
		logic [20:0] exp;
		logic [4:0] msk;
		cmd.op = op;
		cmd.isByte = isByte;
		cmd.opA = a;
		cmd.opB = b;
		busCycle(1'b1, 1'b0, cmd);
		exp = modelExec(op, isByte, a, b, modelCcr);
		modelCcr = exp[20:16];
		// V left unpredicted after BCD
		msk = (op == aluPkg::opAbcd || op == aluPkg::opSbcd) ? 5'b11101 : 5'b11111;
		ccrKnown = msk;
		expQ.push_back(exp);
		maskQ.push_back(msk);
	endtask

	task automatic loadCcr(logic [4:0] val);
		busPkg::aluCmd cmd;
		cmd = '0;
		cmd.opA = {11'h000, val};
		busCycle(1'b1, 1'b1, cmd);
		modelCcr = val;
		ccrKnown = 5'b11111;
	endtask

	task automatic readCcr();
		busCycle(1'b0, 1'b0, '0);
		ccrRead: assert (rsp.dat[15:5] == 11'h000 &&
				(rsp.dat[4:0] & ccrKnown) == (modelCcr & ccrKnown))
			else begin
				valueErrs++;
				$display("mismatch at %0t: CCR read %h, expected %h", $time, rsp.dat,
					modelCcr);
			end
	endtask

	function automatic logic [7:0] randBcd();
		return {4'($unsigned($random(seed)) % 10), 4'($unsigned($random(seed)) % 10)};
	endfunction

	initial begin
		int n;
		aluPkg::aluOp op;
		logic [15:0] a, b;
		for (int i = 0; i < 20; i++)
			allOps[i] = aluPkg::aluOp'(i);
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		repeat (2) @(posedge clk);
		// Logic ops, NOT, EXT
		for (int s = 0; s < 2; s++)
			for (int i = 0; i < 6; i++) begin
				loadCcr(5'($random(seed)));
				runCmd(aluPkg::opAnd, s[0], 16'($random(seed)), 16'($random(seed)));
				runCmd(aluPkg::opOr, s[0], 16'($random(seed)), 16'($random(seed)));
				runCmd(aluPkg::opEor, s[0], 16'($random(seed)), 16'($random(seed)));
				runCmd(aluPkg::opNot, s[0], 16'($random(seed)), 16'($random(seed)));
				runCmd(aluPkg::opExt, s[0], 16'($random(seed)), 16'($random(seed)));
			end
		busIdle();
		// Arithmetic, then X chains with sticky Z
		for (int i = 0; i < 24; i++)
			runCmd(allOps[4 + i % 5], i[1], 16'($random(seed)), 16'($random(seed)));
		loadCcr(5'b00100);
		runCmd(aluPkg::opAddx, 1'b0, 16'h0000, 16'h0000);
		runCmd(aluPkg::opAddx, 1'b0, 16'h0001, 16'h0000);   // Clears Z
		runCmd(aluPkg::opAddx, 1'b0, 16'h0000, 16'h0000);   // Z stays clear
		loadCcr(5'b10100);
		runCmd(aluPkg::opSubx, 1'b1, 16'h00ff, 16'h00ff);   // Borrow from X
		runCmd(aluPkg::opSubx, 1'b1, 16'h0000, 16'h0001);
		busIdle();
		// BCD with random X in
		for (int i = 0; i < 16; i++) begin
			loadCcr({1'($random(seed)), 4'b0100});
			runCmd(i[0] ? aluPkg::opSbcd : aluPkg::opAbcd, 1'b1, {8'h00, randBcd()},
				{8'h00, randBcd()});
		end
		// Shifts and rotates at both sizes
		for (int s = 0; s < 2; s++)
			for (int i = 0; i < 32; i++) begin
				if (i % 8 == 0)
					loadCcr(5'($random(seed)));
				runCmd(allOps[11 + i % 8], s[0], 16'($random(seed)), 16'($random(seed)));
			end
		busIdle();
		// CCR load and read back
		for (int i = 0; i < 6; i++) begin
			loadCcr(5'($random(seed)));
			readCcr();
		end
		// Back-to-back burst, each command sees the CCR of the one before
		for (int i = 0; i < 40; i++) begin
			op = allOps[$unsigned($random(seed)) % 20];
			a = 16'($random(seed));
			b = 16'($random(seed));
			if (op == aluPkg::opAbcd || op == aluPkg::opSbcd) begin
				a = {8'h00, randBcd()};         // Decimal digits only
				b = {8'h00, randBcd()};
			end
			runCmd(op, 1'($random(seed)), a, b);
		end
		readCcr();
		busIdle();
		n = 0;
		while (expQ.size() != 0) begin
			if (n > 50) begin
				protoErrs++;
				$display("timed out waiting for results");
				finishRun();
			end
			n++;
			@(negedge clk);
		end
		repeat (5) @(posedge clk);              // Catch stray res.valid
		finishRun();
	end

endmodule

`default_nettype wire

/* hdl/aluPipe.sv */
////////////////////
// ALU top; result two cycles after the write ack, no back-pressure on res
////////////////////
`timescale 1ns/1ns
`default_nettype none

module aluPipe (
	input  logic          clk,
	input  logic          rstN,
	input  busPkg::wbReq  wbIn,
	output busPkg::wbRsp  wbOut,
	output busPkg::aluRes res
);

	busPkg::decStage dec;
	busPkg::wbRsp exRsp;                         // CCR read data
	logic ack;
	logic [aluPkg::ccrW-1:0] ccrLoadVal;

	// CCR load value rides in opA
	assign ccrLoadVal = dec.opA[aluPkg::ccrW-1:0];

	cmdDecode decode_i (
		.clk (clk),
		.rstN(rstN),
		.wbIn(wbIn),
		.ack (ack),
		.dec (dec)
	);

	aluExecute execute_i (
		.clk  (clk),
		.rstN (rstN),
		.dec  (dec),
		.ccrIn(ccrLoadVal),
		.res  (res),
		.wbOut(exRsp)
	);

	assign wbOut.ack = ack;
	assign wbOut.dat = exRsp.dat;

endmodule

`default_nettype wire

/* hdl/cmdDecode.sv */
////////////////////
// Classic Wishbone slave, one ack per request; no wait states beyond the ack cycle
////////////////////
`timescale 1ns/1ns
`default_nettype none

module cmdDecode (
	input  logic            clk,
	input  logic            rstN,
	input  busPkg::wbReq    wbIn,
	output logic            ack,
	output busPkg::decStage dec
);

	aluPkg::aluOp cmdOp;
	aluPkg::aluCtl nextCtl;
	aluPkg::aluCtl decCtl;
	logic [busPkg::dataW-1:0] decA;
	logic [busPkg::dataW-1:0] decB;
	logic decValid;
	logic accept;

	assign accept = ack & wbIn.cyc & wbIn.stb & wbIn.we; // Request still held in ack cycle
	assign cmdOp = wbIn.adr ? aluPkg::opCcrLoad : wbIn.dat.op;

	// Operation to controls
	always_comb begin
		nextCtl = '0;
		nextCtl.op = cmdOp;
		nextCtl.isByte = wbIn.dat.isByte;
		nextCtl.addCin = aluPkg::cinZero;
		nextCtl.isAdd = 1'b1;
		nextCtl.shiftRight = 1'b0;
		nextCtl.shiftCin = aluPkg::shZero;
		nextCtl.ccrMask = aluPkg::maskNz00;  // Logic ops, ROL, ROR
		nextCtl.stickyZ = 1'b0;
		case (cmdOp)
			aluPkg::opAdd: nextCtl.ccrMask = aluPkg::maskAll;
			aluPkg::opAddx: begin
				nextCtl.addCin = aluPkg::cinX;
				nextCtl.ccrMask = aluPkg::maskAll;
				nextCtl.stickyZ = 1'b1;
			end
			aluPkg::opSub: begin
				nextCtl.isAdd = 1'b0;
				nextCtl.ccrMask = aluPkg::maskAll;
			end
			aluPkg::opSubx: begin
				nextCtl.isAdd = 1'b0;
				nextCtl.addCin = aluPkg::cinX;
				nextCtl.ccrMask = aluPkg::maskAll;
				nextCtl.stickyZ = 1'b1;
			end
			aluPkg::opCmp: begin
				nextCtl.isAdd = 1'b0;
				nextCtl.ccrMask = aluPkg::maskNzvc; // X untouched
			end
			aluPkg::opNot: begin
				nextCtl.isAdd = 1'b0;
				nextCtl.addCin = aluPkg::cinOne;
			end
			aluPkg::opAbcd, aluPkg::opSbcd: begin
				nextCtl.isAdd = (cmdOp == aluPkg::opAbcd);
				nextCtl.addCin = aluPkg::cinX;
				nextCtl.isByte = 1'b1;       // BCD is byte only
				nextCtl.ccrMask = aluPkg::maskBcd;
				nextCtl.stickyZ = 1'b1;
			end
			aluPkg::opExt: nextCtl.isByte = 1'b0; // Word result
			aluPkg::opAsl, aluPkg::opLsl: nextCtl.ccrMask = aluPkg::maskAll;
			aluPkg::opAsr: begin
				nextCtl.shiftRight = 1'b1;
				nextCtl.shiftCin = aluPkg::shMsb; // Sign fill
				nextCtl.ccrMask = aluPkg::maskAll;
			end
			aluPkg::opLsr: begin
				nextCtl.shiftRight = 1'b1;
				nextCtl.ccrMask = aluPkg::maskAll;
			end
			aluPkg::opRol: nextCtl.shiftCin = aluPkg::shMsb;
			aluPkg::opRor: begin
				nextCtl.shiftRight = 1'b1;
				nextCtl.shiftCin = aluPkg::shLsb;
			end
			aluPkg::opRoxl, aluPkg::opRoxr: begin
				nextCtl.shiftRight = (cmdOp == aluPkg::opRoxr);
				nextCtl.shiftCin = aluPkg::shX; // Rotate through X
				nextCtl.ccrMask = aluPkg::maskAll;
			end
			default: ;                       // AND, OR, EOR, CCR load
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ack <= 1'b0;
			decValid <= 1'b0;
		end else begin
			ack <= wbIn.cyc & wbIn.stb & ~ack; // Single-cycle pulse
			decValid <= accept;
		end
	end

	// Payload, no reset
	always_ff @(posedge clk) begin
		if (accept) begin
			decCtl <= nextCtl;
			decA <= wbIn.dat.opA;
			decB <= wbIn.dat.opB;
		end
	end

	assign dec.valid = decValid;
	assign dec.ctl = decCtl;
	assign dec.opA = decA;
	assign dec.opB = decB;

endmodule

`default_nettype wire

/* hdl/aluExecute.sv */
////////////////////
// Execute stage; result and CCR registered together, byte results have a zero upper byte
////////////////////
`timescale 1ns/1ns
`default_nettype none

module aluExecute (
	input  logic                    clk,
	input  logic                    rstN,
	input  busPkg::decStage         dec,
	input  logic [aluPkg::ccrW-1:0] ccrIn,
	output busPkg::aluRes           res,
	output busPkg::wbRsp            wbOut
);

	logic [aluPkg::ccrW-1:0] ccr;
	logic [busPkg::dataW-1:0] opA;
	logic [busPkg::dataW-1:0] bIn;
	logic [busPkg::dataW-1:0] addRes;
	logic [busPkg::dataW-1:0] shiftRes;
	logic [busPkg::dataW-1:0] nextRes;
	logic [busPkg::dataW-1:0] resData;
	logic [16:0] sumW;
	logic [8:0] sumB;
	logic [7:0] bcdRes;
	logic cin, addC, addV, hCarry;
	logic msbA, msbB, msbR, srcSign;
	logic shiftIn, shiftOutBit, shiftVChange;
	logic bcdC, bcdV, resValid;

	assign opA = dec.opA;
	assign bIn = (dec.ctl.op == aluPkg::opNot) ? '0 : dec.opB; // NOT is 0 - opA - 1
	assign msbA = dec.ctl.isByte ? opA[7] : opA[15];

	// Adder, data side minus addressing side
	always_comb begin
		case (dec.ctl.addCin)
			aluPkg::cinOne: cin = 1'b1;
			aluPkg::cinX:   cin = ccr[aluPkg::flagX];
			default:        cin = 1'b0;
		endcase
		if (dec.ctl.isAdd) begin
			sumW = {1'b0, bIn} + {1'b0, opA} + 17'(cin);
			sumB = {1'b0, bIn[7:0]} + {1'b0, opA[7:0]} + 9'(cin);
		end else begin
			sumW = {1'b0, bIn} - {1'b0, opA} - 17'(cin);
			sumB = {1'b0, bIn[7:0]} - {1'b0, opA[7:0]} - 9'(cin);
		end
		addRes = dec.ctl.isByte ? {8'h00, sumB[7:0]} : sumW[15:0];
		addC = dec.ctl.isByte ? sumB[8] : sumW[16];     // Borrow on subtract
		msbB = dec.ctl.isByte ? bIn[7] : bIn[15];
		msbR = dec.ctl.isByte ? sumB[7] : sumW[15];
		srcSign = dec.ctl.isAdd ? msbA : ~msbA;
		addV = (srcSign & msbB & ~msbR) | (~srcSign & ~msbB & msbR);
		hCarry = opA[4] ^ bIn[4] ^ sumB[4];            // Carry into bit 4
	end

	// Shift-in bit and what falls out
	always_comb begin
		case (dec.ctl.shiftCin)
			aluPkg::shMsb: shiftIn = msbA;
			aluPkg::shLsb: shiftIn = opA[0];
			aluPkg::shX:   shiftIn = ccr[aluPkg::flagX];
			default:       shiftIn = 1'b0;
		endcase
		shiftOutBit = dec.ctl.shiftRight ? opA[0] : msbA;
		shiftVChange = msbA ^ (dec.ctl.isByte ? opA[6] : opA[14]); // ASL sign change
	end

	aluShifter shifter_i (
		.data      (opA),
		.isByte    (dec.ctl.isByte),
		.shiftRight(dec.ctl.shiftRight),
		.cin       (shiftIn),
		.result    (shiftRes)
	);

	// Byte carry or borrow forces the high-digit fix
	bcdAdjust bcd_i (
		.binResult(sumB[7:0]),
		.isAdd    (dec.ctl.isAdd),
		.hCarry   (hCarry),
		.xIn      (sumB[8]),
		.bcdResult(bcdRes),
		.decCarry (bcdC),
		.ov       (bcdV)
	);

	// Result select
	always_comb begin
		case (dec.ctl.op)
			aluPkg::opAnd: nextRes = opA & dec.opB;
			aluPkg::opOr:  nextRes = opA | dec.opB;
			aluPkg::opEor: nextRes = opA ^ dec.opB;
			aluPkg::opExt: nextRes = {{8{opA[7]}}, opA[7:0]};
			aluPkg::opNot, aluPkg::opAdd, aluPkg::opAddx,
			aluPkg::opSub, aluPkg::opSubx, aluPkg::opCmp: nextRes = addRes;
			aluPkg::opAbcd, aluPkg::opSbcd: nextRes = {8'h00, bcdRes};
			aluPkg::opAsl, aluPkg::opAsr, aluPkg::opLsl, aluPkg::opLsr,
			aluPkg::opRol, aluPkg::opRor, aluPkg::opRoxl, aluPkg::opRoxr: nextRes = shiftRes;
			default: nextRes = '0;               // CCR load
		endcase
		if (dec.ctl.isByte)
			nextRes[15:8] = 8'h00;
	end

	ccrUnit ccr_i (
		.clk         (clk),
		.rstN        (rstN),
		.ctl         (dec.ctl),
		.valid       (dec.valid),
		.result      (nextRes),
		.addC        (addC),
		.addV        (addV),
		.bcdC        (bcdC),
		.bcdV        (bcdV),
		.shiftOutBit (shiftOutBit),
		.shiftVChange(shiftVChange),
		.loadValue   (ccrIn),
		.ccr         (ccr)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			resValid <= 1'b0;
		else
			resValid <= dec.valid & (dec.ctl.op != aluPkg::opCcrLoad);
	end

	always_ff @(posedge clk) begin
		if (dec.valid)
			resData <= nextRes;
	end

	assign res.valid = resValid;
	assign res.result = resData;
	assign res.ccr = ccr;                        // Updated at the same edge as resData

	assign wbOut.ack = 1'b0;                     // Ack comes from the decode stage
	assign wbOut.dat = {{(busPkg::dataW - aluPkg::ccrW){1'b0}}, ccr};

endmodule

`default_nettype wire

/* hdl/ccrUnit.sv */
////////////////////
// CCR update per masked op; a CCR load overrides the mask
////////////////////
`timescale 1ns/1ns
`default_nettype none

module ccrUnit (
	input  logic                    clk,
	input  logic                    rstN,
	input  aluPkg::aluCtl           ctl,
	input  logic                    valid,
	input  logic [15:0]             result,
	input  logic                    addC,
	input  logic                    addV,
	input  logic                    bcdC,
	input  logic                    bcdV,
	input  logic                    shiftOutBit,
	input  logic                    shiftVChange,
	input  logic [aluPkg::ccrW-1:0] loadValue,
	output logic [aluPkg::ccrW-1:0] ccr
);

	logic [aluPkg::ccrW-1:0] raw;
	logic [aluPkg::ccrW-1:0] merged;

	// Raw flags from the op's source
	always_comb begin
		raw = '0;                            // C and V clear for logic ops
		raw[aluPkg::flagX] = ccr[aluPkg::flagX];
		raw[aluPkg::flagN] = ctl.isByte ? result[7] : result[15];
		raw[aluPkg::flagZ] = ctl.isByte ? (result[7:0] == 8'h00) : (result == 16'h0000);
		case (ctl.op)
			aluPkg::opAdd, aluPkg::opAddx, aluPkg::opSub,
			aluPkg::opSubx, aluPkg::opCmp: begin
				raw[aluPkg::flagC] = addC;
				raw[aluPkg::flagX] = addC;    // Masked off for CMP
				raw[aluPkg::flagV] = addV;
			end
			aluPkg::opAbcd, aluPkg::opSbcd: begin
				raw[aluPkg::flagC] = bcdC;
				raw[aluPkg::flagX] = bcdC;
				raw[aluPkg::flagV] = bcdV;
			end
			aluPkg::opAsl: begin
				raw[aluPkg::flagC] = shiftOutBit;
				raw[aluPkg::flagX] = shiftOutBit;
				raw[aluPkg::flagV] = shiftVChange; // MSB changed
			end
			aluPkg::opAsr, aluPkg::opLsl, aluPkg::opLsr,
			aluPkg::opRoxl, aluPkg::opRoxr: begin
				raw[aluPkg::flagC] = shiftOutBit;
				raw[aluPkg::flagX] = shiftOutBit;
			end
			aluPkg::opRol, aluPkg::opRor: raw[aluPkg::flagC] = shiftOutBit; // X untouched
			default: ;
		endcase
	end

	// Mask merge
	always_comb begin
		merged = (raw & ctl.ccrMask) | (ccr & ~ctl.ccrMask);
		if (ctl.stickyZ)
			merged[aluPkg::flagZ] = raw[aluPkg::flagZ] & ccr[aluPkg::flagZ]; // Clear only
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			ccr <= '0;
		else if (valid)
			ccr <= (ctl.op == aluPkg::opCcrLoad) ? loadValue : merged;
	end

endmodule

`default_nettype wire

/* hdl/bcdAdjust.sv */
////////////////////
// Packed BCD correction of one byte; xIn is the binary carry or borrow of that byte
////////////////////
`timescale 1ns/1ns
`default_nettype none

module bcdAdjust (
	input  logic [7:0] binResult,
	input  logic       isAdd,
	input  logic       hCarry,
	input  logic       xIn,
	output logic [7:0] bcdResult,
	output logic       decCarry,
	output logic       ov
);

	logic [8:0] lowAdj;
	logic [4:0] highAdj;
	logic lowFix, highFix;

	// Nibble above 9
	function automatic logic gt9(input logic [3:0] nib);
		return nib[3] & (nib[2] | nib[1]);
	endfunction

	always_comb begin
		lowFix = hCarry | (isAdd & gt9(binResult[3:0]));
		if (isAdd) begin
			lowAdj = {1'b0, binResult} + (lowFix ? 9'h6 : 9'h0);
			highFix = xIn | gt9(lowAdj[7:4]) | lowAdj[8];
			highAdj = lowAdj[8:4] + (highFix ? 5'h6 : 5'h0);
			ov = highAdj[3] & ~binResult[7];
		end else begin
			lowAdj = {1'b0, binResult} - (lowFix ? 9'h6 : 9'h0);
			highFix = xIn;                   // Only a borrow corrects the high digit
			highAdj = lowAdj[8:4] - (highFix ? 5'h6 : 5'h0);
			ov = ~highAdj[3] & binResult[7];
		end
	end

	assign bcdResult = {highAdj[3:0], lowAdj[3:0]};
	assign decCarry = highAdj[4] | xIn;          // Decimal carry or borrow

endmodule

`default_nettype wire

/* hdl/aluShifter.sv */
////////////////////
// One-bit shift or rotate; upper byte is junk on byte operands
////////////////////
`timescale 1ns/1ns
`default_nettype none

module aluShifter (
	input  logic [15:0] data,
	input  logic        isByte,
	input  logic        shiftRight,
	input  logic        cin,
	output logic [15:0] result
);

	logic [15:0] sized;

	always_comb begin
		sized = data;
		if (isByte)
			sized[8] = cin;                  // Lands at bit 7 on a right shift
		if (shiftRight)
			result = {cin, sized[15:1]};
		else
			result = {sized[14:0], cin};     // Left always fills bit 0
	end

endmodule

`default_nettype wire

/* hdl/busPkg.sv */
////////////////////
// Wishbone command port and result bus; adr is one bit, reads return the CCR only
////////////////////
`default_nettype none

package busPkg;

	localparam int dataW = 16;

	// Self-contained command, 38 bits
	typedef struct packed {
		aluPkg::aluOp     op;
		logic             isByte;
		logic [dataW-1:0] opA;              // Addressing side
		logic [dataW-1:0] opB;              // Data side
	} aluCmd;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		logic  adr;                         // 0 command, 1 CCR load
		aluCmd dat;
	} wbReq;

	typedef struct packed {
		logic             ack;
		logic [dataW-1:0] dat;              // CCR, zero-extended
	} wbRsp;

	typedef struct packed {
		logic                    valid;
		logic [dataW-1:0]        result;
		logic [aluPkg::ccrW-1:0] ccr;
	} aluRes;

	// Decode to execute
	typedef struct packed {
		logic             valid;
		aluPkg::aluCtl    ctl;
		logic [dataW-1:0] opA;
		logic [dataW-1:0] opB;
	} decStage;

endpackage

`default_nettype wire

/* hdl/aluPkg.sv */
////////////////////
// ALU opcodes, CCR layout and decoded controls; only one-bit shifts, byte or word size
////////////////////
`default_nettype none

package aluPkg;

	localparam int ccrW = 5;                // X N Z V C

	// Flag bit positions within the CCR
	localparam int flagC = 0;
	localparam int flagV = 1;
	localparam int flagZ = 2;
	localparam int flagN = 3;
	localparam int flagX = 4;

	// Update masks, set bit takes the new flag
	localparam logic [ccrW-1:0] maskNz00 = 5'b01111; // C, V forced clear by the raw flags
	localparam logic [ccrW-1:0] maskNzvc = 5'b01111; // X kept
	localparam logic [ccrW-1:0] maskAll  = 5'b11111;
	localparam logic [ccrW-1:0] maskBcd  = 5'b11111; // Paired with sticky Z

	// Operation already decoded by the master
	typedef enum logic [4:0] {
		opAnd     = 5'd0,
		opOr      = 5'd1,
		opEor     = 5'd2,
		opNot     = 5'd3,
		opAdd     = 5'd4,
		opAddx    = 5'd5,
		opSub     = 5'd6,
		opSubx    = 5'd7,
		opCmp     = 5'd8,
		opAbcd    = 5'd9,
		opSbcd    = 5'd10,
		opAsl     = 5'd11,
		opAsr     = 5'd12,
		opLsl     = 5'd13,
		opLsr     = 5'd14,
		opRol     = 5'd15,
		opRor     = 5'd16,
		opRoxl    = 5'd17,
		opRoxr    = 5'd18,
		opExt     = 5'd19,
		opCcrLoad = 5'd20                   // Writes opA[4:0] into the CCR
	} aluOp;

	// Adder carry-in source
	typedef enum logic [1:0] {
		cinZero = 2'd0,
		cinOne  = 2'd1,                     // NOT as 0 - op - 1
		cinX    = 2'd2
	} addCinSel;

	// Bit shifted into the vacated end
	typedef enum logic [1:0] {
		shZero = 2'd0,
		shMsb  = 2'd1,
		shLsb  = 2'd2,
		shX    = 2'd3
	} shiftCinSel;

	typedef struct packed {
		aluOp            op;
		logic            isByte;
		addCinSel        addCin;
		logic            isAdd;             // Else opB - opA - cin
		logic            shiftRight;
		shiftCinSel      shiftCin;
		logic [ccrW-1:0] ccrMask;
		logic            stickyZ;           // Z can only be cleared
	} aluCtl;

endpackage

`default_nettype wire
